//--- include/readout_settings.svh
`ifndef READOUT_SETTINGS_SVH
`define READOUT_SETTINGS_SVH

//////////////////////////////
// link and memory widths
//////////////////////////////
`define RD_WORD_W            32                      // one word on the serial link
`define RD_BURST_W           128                     // one burst out of the read fifo
`define RD_WORDS_PER_BURST   4                       // link words carved from each burst

//////////////////////////////
// read request counting
//////////////////////////////
`define RD_BURST_CNT_W       24                      // requested burst count
`define RD_WORD_CNT_W        (`RD_BURST_CNT_W + 2)   // bursts times four, in words

// flops between the async readout_pause pin and clk125 logic
`define RD_PAUSE_SYNC_STAGES 2

`endif

//--- rtl/readout_pkg.sv
`include "readout_settings.svh"

package readout_pkg;

  //////////////////////////////
  // stream beats
  //////////////////////////////

  // one 32-bit beat toward the link, or from the command processor
  typedef struct packed {
    logic                  valid;  // beat present
    logic                  last;   // closes a packet
    logic [`RD_WORD_W-1:0] data;   // link word
  } link_beat_t;

  // one 128-bit burst as it leaves the read fifo
  typedef struct packed {
    logic                   valid;  // burst present
    logic                   last;   // final burst of the fill
    logic [`RD_BURST_W-1:0] data;   // words 3..0, word 0 in the low bits
  } burst_beat_t;

  //////////////////////////////
  // readout controller
  //////////////////////////////

  // IDLE          link belongs to the command processor
  // WAIT_CMD_END  request taken, letting an open command packet finish
  // SEND_DDR3     link belongs to stored waveform data
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    WAIT_CMD_END = 2'd1,
    SEND_DDR3    = 2'd2
  } readout_state_e;

endpackage

//--- rtl/readout_fsm.sv
`timescale 1ns/1ps

`include "readout_settings.svh"

module readout_fsm (
  input  logic                       clk125,
  input  logic                       rst_n,
  input  logic                       rd_start,        // one-cycle read request
  input  logic [`RD_BURST_CNT_W-1:0] rd_burst_cnt,    // bursts asked for
  input  logic                       cmd_accept,      // command beat went out on the link
  input  logic                       cmd_last,        // ...and it closed its packet
  input  logic                       ddr3_accept,     // memory word went out on the link
  input  logic                       words_left_one,  // counter is on the final word
  output logic                       use_ddr3,        // link source select
  output logic                       cnt_load,        // load pulse toward the counter
  output logic [`RD_BURST_CNT_W-1:0] load_bursts,     // latched burst count
  output logic                       rd_done          // one-cycle end of read
);

  readout_pkg::readout_state_e state, state_nxt;

  logic cmd_open;      // inside a command packet
  logic cmd_open_nxt;  // packet state including this cycle's transfer
  logic req_ok;        // request that will be honored
  logic final_word;    // last owed memory word is transferring now

  //////////////////////////////
  // command packet tracking
  //////////////////////////////
  assign cmd_open_nxt = cmd_accept ? !cmd_last : cmd_open;  // beat with last closes it

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      cmd_open <= 1'b0;
    end else begin
      cmd_open <= cmd_open_nxt;
    end
  end

  //////////////////////////////
  // state machine
  //////////////////////////////
  assign req_ok     = (state == readout_pkg::IDLE) && rd_start && (rd_burst_cnt != '0);
  assign final_word = (state == readout_pkg::SEND_DDR3) && ddr3_accept && words_left_one;
  assign use_ddr3   = (state == readout_pkg::SEND_DDR3);  // link granted to memory only here

  always_comb begin
    state_nxt = state;
    case (state)
      readout_pkg::IDLE: begin
        if (req_ok) begin
          // a packet opening this very cycle still counts as open
          state_nxt = cmd_open_nxt ? readout_pkg::WAIT_CMD_END : readout_pkg::SEND_DDR3;
        end
      end
      readout_pkg::WAIT_CMD_END: begin
        if (cmd_accept && cmd_last) begin
          state_nxt = readout_pkg::SEND_DDR3;  // switch right after the closing beat
        end
      end
      readout_pkg::SEND_DDR3: begin
        if (final_word) begin
          state_nxt = readout_pkg::IDLE;  // hand the link back
        end
      end
      default: state_nxt = readout_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= readout_pkg::IDLE;
      cnt_load <= 1'b0;
      rd_done  <= 1'b0;
    end else begin
      state    <= state_nxt;
      cnt_load <= req_ok;      // lines up with the latched count below
      rd_done  <= final_word;  // strobe in the cycle after the final word
    end
  end

  always_ff @(posedge clk125) begin
    if (req_ok) begin
      load_bursts <= rd_burst_cnt;  // held for the counter load
    end
  end

endmodule

//--- rtl/word_counter.sv
`timescale 1ns/1ps

`include "readout_settings.svh"

module word_counter (
  input  logic                       clk125,
  input  logic                       rst_n,
  input  logic                       cnt_load,        // start of a new read
  input  logic [`RD_BURST_CNT_W-1:0] load_bursts,     // bursts in this read
  input  logic                       ddr3_accept,     // one memory word left on the link
  output logic                       words_left_one   // exactly one word still owed
);

  localparam int CNT_W = `RD_WORD_CNT_W;

  logic [CNT_W-1:0] count;       // words still owed
  logic [CNT_W-1:0] load_words;  // bursts scaled to words

  assign load_words = CNT_W'(load_bursts) * CNT_W'(`RD_WORDS_PER_BURST);

  //////////////////////////////
  // down-counter
  //////////////////////////////
  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (cnt_load) begin
      // the first word can already leave in the load cycle
      count <= ddr3_accept ? load_words - 1'b1 : load_words;
    end else if (ddr3_accept && (count != '0)) begin
      count <= count - 1'b1;  // one word delivered
    end
  end

  // lets the fsm end the read on the final transfer itself
  assign words_left_one = (count == CNT_W'(1));

endmodule

//--- rtl/burst_width_converter.sv
`timescale 1ns/1ps

`include "readout_settings.svh"

module burst_width_converter (
  input  logic                     clk125,
  input  logic                     rst_n,
  input  readout_pkg::burst_beat_t ddr3_rd,        // bursts from the read fifo
  input  logic                     word_ready,     // mux can take a word
  output logic                     ddr3_rd_ready,  // can take a burst
  output readout_pkg::link_beat_t  ddr3_word       // 32-bit words toward the mux
);

  localparam int IDX_W = $clog2(`RD_WORDS_PER_BURST);

  logic                   full;        // output register holds a burst
  logic [IDX_W-1:0]       idx;         // word currently presented
  logic [`RD_BURST_W-1:0] buf_data;    // held burst
  logic                   buf_last;    // held burst closed the fill
  logic                   accept_en;   // opens one edge after reset
  logic                   last_word;   // presenting word 3
  logic                   take_word;   // word leaves this cycle
  logic                   take_burst;  // burst arrives this cycle

  //////////////////////////////
  // handshakes
  //////////////////////////////
  assign last_word  = (idx == IDX_W'(`RD_WORDS_PER_BURST - 1));
  assign take_word  = full && word_ready;
  // room when empty, or when word 3 is draining this cycle
  assign ddr3_rd_ready = accept_en && (!full || (take_word && last_word));
  assign take_burst = ddr3_rd.valid && ddr3_rd_ready;

  //////////////////////////////
  // control
  //////////////////////////////
  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      accept_en <= 1'b0;
      full      <= 1'b0;
      idx       <= '0;
    end else begin
      accept_en <= 1'b1;
      if (take_burst) begin
        full <= 1'b1;  // back to back with the old burst's last word
        idx  <= '0;    // low word goes first
      end else if (take_word) begin
        if (last_word) begin
          full <= 1'b0;  // burst drained
        end
        idx <= idx + 1'b1;  // wraps to 0 after word 3
      end
    end
  end

  // burst payload
  always_ff @(posedge clk125) begin
    if (take_burst) begin
      buf_data <= ddr3_rd.data;
      buf_last <= ddr3_rd.last;
    end
  end

  //////////////////////////////
  // word output
  //////////////////////////////
  assign ddr3_word.valid = full;
  assign ddr3_word.last  = buf_last && last_word;  // only word 3 carries last
  assign ddr3_word.data  = buf_data[idx*`RD_WORD_W +: `RD_WORD_W];

endmodule

//--- rtl/link_tx_mux.sv
`timescale 1ns/1ps

`include "readout_settings.svh"

module link_tx_mux (
  input  logic                    clk125,
  input  logic                    rst_n,
  input  logic                    readout_pause,  // async, from the master fpga
  input  logic                    use_ddr3,       // 1 selects memory words
  input  readout_pkg::link_beat_t cmd_tx,         // command processor beats
  input  readout_pkg::link_beat_t ddr3_word,      // converter words
  input  logic                    link_ready,     // link can take a beat
  output readout_pkg::link_beat_t link_tx,        // beat toward the link
  output logic                    cmd_tx_ready,   // ready back to the command source
  output logic                    word_ready,     // ready back to the converter
  output logic                    cmd_accept,     // command beat transferred
  output logic                    ddr3_accept     // memory word transferred
);

  localparam int SYNC_N = `RD_PAUSE_SYNC_STAGES;

  logic [SYNC_N-1:0] pause_sync;  // synchronizer chain, oldest in the top bit
  logic              paused;      // synchronized pause
  logic              link_open;   // link free to take a beat

  //////////////////////////////
  // pause synchronizer
  //////////////////////////////
  // comes out of reset paused so nothing moves until the pin has been sampled
  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      pause_sync <= '1;
    end else begin
      pause_sync <= {pause_sync[SYNC_N-2:0], readout_pause};
    end
  end

  assign paused    = pause_sync[SYNC_N-1];
  assign link_open = link_ready && !paused;

  //////////////////////////////
  // 2:1 source switch
  //////////////////////////////
  always_comb begin
    link_tx       = use_ddr3 ? ddr3_word : cmd_tx;  // valid, last and data follow the select
    link_tx.valid = link_tx.valid && !paused;       // hold the link off while paused
  end

  // only the selected source ever sees ready
  assign word_ready   = use_ddr3 && link_open;
  assign cmd_tx_ready = !use_ddr3 && link_open;

  // transfer reports for the fsm and counter
  assign cmd_accept  = cmd_tx_ready && cmd_tx.valid;
  assign ddr3_accept = word_ready && ddr3_word.valid;

endmodule

//--- rtl/chan_readout_top.sv
`timescale 1ns/1ps

`include "readout_settings.svh"

module chan_readout_top (
  input  logic                       clk125,
  input  logic                       rst_n,
  // command processor stream
  input  readout_pkg::link_beat_t    cmd_tx,
  output logic                       cmd_tx_ready,
  // read fifo stream
  input  readout_pkg::burst_beat_t   ddr3_rd,
  output logic                       ddr3_rd_ready,
  // serial link
  output readout_pkg::link_beat_t    link_tx,
  input  logic                       link_ready,
  input  logic                       readout_pause,  // async
  // read request
  input  logic                       rd_start,
  input  logic [`RD_BURST_CNT_W-1:0] rd_burst_cnt,
  output logic                       rd_done
);

  readout_pkg::link_beat_t    ddr3_word;       // converter to mux
  logic                       word_ready;      // mux back to converter
  logic                       use_ddr3;        // link source select
  logic                       cmd_accept;      // command beat sent
  logic                       ddr3_accept;     // memory word sent
  logic                       cnt_load;        // new read
  logic [`RD_BURST_CNT_W-1:0] load_bursts;     // its burst count
  logic                       words_left_one;  // final word owed

  //////////////////////////////
  // readout control
  //////////////////////////////
  readout_fsm u_fsm (
    .clk125         (clk125),
    .rst_n          (rst_n),
    .rd_start       (rd_start),
    .rd_burst_cnt   (rd_burst_cnt),
    .cmd_accept     (cmd_accept),
    .cmd_last       (cmd_tx.last),
    .ddr3_accept    (ddr3_accept),
    .words_left_one (words_left_one),
    .use_ddr3       (use_ddr3),
    .cnt_load       (cnt_load),
    .load_bursts    (load_bursts),
    .rd_done        (rd_done)
  );

  word_counter u_word_counter (
    .clk125         (clk125),
    .rst_n          (rst_n),
    .cnt_load       (cnt_load),
    .load_bursts    (load_bursts),
    .ddr3_accept    (ddr3_accept),
    .words_left_one (words_left_one)
  );

  //////////////////////////////
  // data path
  //////////////////////////////
  burst_width_converter u_converter (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .ddr3_rd       (ddr3_rd),
    .word_ready    (word_ready),
    .ddr3_rd_ready (ddr3_rd_ready),
    .ddr3_word     (ddr3_word)
  );

  link_tx_mux u_link_mux (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .readout_pause (readout_pause),
    .use_ddr3      (use_ddr3),
    .cmd_tx        (cmd_tx),
    .ddr3_word     (ddr3_word),
    .link_ready    (link_ready),
    .link_tx       (link_tx),
    .cmd_tx_ready  (cmd_tx_ready),
    .word_ready    (word_ready),
    .cmd_accept    (cmd_accept),
    .ddr3_accept   (ddr3_accept)
  );

endmodule

//--- verif/tb_chan_readout.sv
`timescale 1ns/1ps

`include "readout_settings.svh"

module tb_chan_readout;

  localparam int    CLK_PERIOD = 100;                        // ns
  localparam int    DRIVE_DLY  = 10;                         // input skew after the edge
  localparam string STIM_FILE  = "verif/readout_input.txt";

  bit                         clk125;
  logic                       rst_n;
  readout_pkg::link_beat_t    cmd_tx;
  logic                       cmd_tx_ready;
  readout_pkg::burst_beat_t   ddr3_rd;
  logic                       ddr3_rd_ready;
  readout_pkg::link_beat_t    link_tx;
  logic                       link_ready;
  logic                       readout_pause;
  logic                       rd_start;
  logic [`RD_BURST_CNT_W-1:0] rd_burst_cnt;
  logic                       rd_done;

  logic [`RD_WORD_W:0]  cmd_q[$];     // {last, data} waiting for the command source
  logic [`RD_BURST_W:0] burst_q[$];   // {last, data} waiting for the read fifo model
  logic [`RD_WORD_W:0]  exp_q[$];     // link beats still expected, in order
  byte                  act_kind[$];  // file actions in order
  logic [159:0]         act_args[$];  // up to five hex fields per action

  int unsigned lcg_state = 47598;
  logic [15:0] ready_mask;            // rotating link_ready allow pattern
  int          cyc, pause_from, pause_to, pause_edges;
  bit          cmd_took, burst_took;  // handshakes seen at the last falling edge
  bit          read_active, pkt_open, loaded;
  int          words_owed, exp_done, done_seen;
  int          words_checked, mismatch_cnt, proto_cnt, timeout_cnt;

  chan_readout_top UUT (.*);

  initial begin
    clk125 = 1'b0;
    forever #(CLK_PERIOD / 2) clk125 = ~clk125;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // upper bits are the better ones
  endfunction

  task automatic check_value(string name, logic [31:0] want, logic [31:0] got);
    assert (got === want) else begin
      mismatch_cnt++;
      $display("mismatch at %0d ns: %s expected %h got %h", $time, name, want, got);
    end
  endtask

  task automatic check_reset_outputs();
    check_value("link_tx.valid", 32'd0, 32'(link_tx.valid));
    check_value("cmd_tx_ready", 32'd0, 32'(cmd_tx_ready));
    check_value("ddr3_rd_ready", 32'd0, 32'(ddr3_rd_ready));
    check_value("rd_done", 32'd0, 32'(rd_done));
  endtask

  // one clock of stimulus, inputs change just after the rising edge
  task automatic drive_cycle(logic start, logic [`RD_BURST_CNT_W-1:0] bursts);
    @(posedge clk125);
    #(DRIVE_DLY);
    cyc++;
    if (cmd_took) cmd_tx.valid = 1'b0;      // beat left, slot free
    if (burst_took) ddr3_rd.valid = 1'b0;
    if (!cmd_tx.valid && cmd_q.size() > 0 && next_random() % 4 != 0)
      cmd_tx = {1'b1, cmd_q.pop_front()};   // held until taken
    if (!ddr3_rd.valid && burst_q.size() > 0 && next_random() % 4 != 0)
      ddr3_rd = {1'b1, burst_q.pop_front()};
    ready_mask    = {ready_mask[14:0], ready_mask[15]};
    link_ready    = ready_mask[15] && (next_random() % 4 != 0);
    readout_pause = (cyc >= pause_from) && (cyc < pause_to);
    rd_start      = start;
    rd_burst_cnt  = bursts;
  endtask

  // honored only from idle with a nonzero count
  task automatic issue_request(logic [`RD_BURST_CNT_W-1:0] bursts);
    drive_cycle(1'b1, bursts);
    if (!read_active && bursts != '0) begin
      read_active = 1'b1;
      words_owed  = `RD_WORDS_PER_BURST * int'(bursts);
      exp_done++;
    end
  endtask

  task automatic load_stimulus(int fd);
    string       line;
    byte         kind;
    logic [31:0] a, b, c, d, e;
    int          n;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h %h %h %h", kind, a, b, c, d, e);
        if (kind == "E") begin
          exp_q.push_back({b[0], a});       // expected beat, straight to the list
        end else begin
          act_kind.push_back(kind);
          act_args.push_back({e, d, c, b, a});
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_actions();
    logic [31:0] a, b, c, d, e;
    byte         kind;
    for (int i = 0; i < act_kind.size(); i++) begin
      kind = act_kind[i];
      {e, d, c, b, a} = act_args[i];
      case (kind)
        "C": cmd_q.push_back({b[0], a});
        "B": burst_q.push_back({e[0], d, c, b, a});  // word 0 in the low bits
        "L": ready_mask = a[15:0];
        "P": begin
          pause_from = cyc + int'(a);       // window relative to now
          pause_to   = pause_from + int'(b);
        end
        "D": repeat (a) drive_cycle(1'b0, '0);
        "A": while (cmd_q.size() > 0 || cmd_tx.valid) drive_cycle(1'b0, '0);
        "S": while (burst_q.size() > 0 || read_active) drive_cycle(1'b0, '0);
        "R": issue_request(a[`RD_BURST_CNT_W-1:0]);
        default: ;
      endcase
    end
  endtask

  //////////////////////////////
  // scoreboard
  //////////////////////////////
  task automatic check_link_beat();
    logic [`RD_WORD_W:0] want;
    assert (exp_q.size() > 0) else begin
      proto_cnt++;
      $display("%0d ns: link word %h arrived with nothing left to expect", $time, link_tx.data);
    end
    if (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      words_checked++;
      check_value("link_tx.data", want[`RD_WORD_W-1:0], link_tx.data);
      check_value("link_tx.last", 32'(want[`RD_WORD_W]), 32'(link_tx.last));
    end
    if (!cmd_took) begin                    // not a command beat, so memory data
      assert (read_active && words_owed > 0 && !pkt_open) else begin
        proto_cnt++;
        $display("%0d ns: memory word sent outside a read or inside a command packet", $time);
      end
      if (words_owed > 0) words_owed--;
    end
  endtask

  always @(posedge clk125) begin
    if (readout_pause) pause_edges <= pause_edges + 1;  // edges the pin has been high
    else pause_edges <= 0;
  end

  always @(negedge clk125) begin
    if (!rst_n) begin
      check_reset_outputs();
    end else begin
      cmd_took   = cmd_tx.valid && cmd_tx_ready;
      burst_took = ddr3_rd.valid && ddr3_rd_ready;
      if (link_tx.valid && link_ready) check_link_beat();
      if (cmd_took) pkt_open = !cmd_tx.last;
      if (rd_done) begin
        done_seen++;
        assert (read_active && words_owed == 0) else begin
          proto_cnt++;
          $display("%0d ns: rd_done without a finished read", $time);
        end
        read_active = 1'b0;
      end
      if (pause_edges > `RD_PAUSE_SYNC_STAGES)
        check_value("link_tx.valid", 32'd0, 32'(link_tx.valid));  // link held off
    end
  end

  //////////////////////////////
  // run control
  //////////////////////////////
  task automatic finish_run();
    $display("checked %0d link words: %0d mismatches, %0d protocol errors, %0d timeouts",
             words_checked, mismatch_cnt, proto_cnt, timeout_cnt);
    if (mismatch_cnt + proto_cnt + timeout_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin
    int limit;
    wait (loaded);
    limit = 40 * exp_q.size() + 200;        // cycles
    #(limit * CLK_PERIOD);
    timeout_cnt++;
    $display("timeout: run not finished after %0d cycles, %0d expected link words missing",
             limit, exp_q.size());
    finish_run();
  end

  initial begin
    int fd;
    rst_n         = 1'b0;
    cmd_tx        = '0;
    ddr3_rd       = '0;
    link_ready    = 1'b1;
    readout_pause = 1'b0;
    rd_start      = 1'b0;
    rd_burst_cnt  = '0;
    ready_mask    = 16'hffff;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      proto_cnt++;
      $display("could not open the stimulus file %s", STIM_FILE);
    end else begin
      load_stimulus(fd);
      loaded = 1'b1;
      repeat (5) @(posedge clk125);
      #(DRIVE_DLY);
      rst_n = 1'b1;
      @(negedge clk125);
      check_reset_outputs();                // first cycle out of reset
      run_actions();
      while (exp_q.size() > 0 || read_active) drive_cycle(1'b0, '0);
      repeat (10) drive_cycle(1'b0, '0);    // room for stray words or strobes
      check_value("rd_done count", 32'(exp_done), 32'(done_seen));
    end
    finish_run();
  end

endmodule

//--- sim.f
+incdir+include
rtl/readout_pkg.sv
rtl/readout_fsm.sv
rtl/word_counter.sv
rtl/burst_width_converter.sv
rtl/link_tx_mux.sv
rtl/chan_readout_top.sv
verif/tb_chan_readout.sv

//--- Makefile
# readout path simulation with Verilator, run from the project root
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_chan_readout
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/readout_input.txt
# C data last | B w0 w1 w2 w3 last | R bursts | P delay len | L ready mask | D cycles
# A waits for the command queue | S waits for the read | E data last, expected on the link
L f7bd
C 11110001 0
C 11110002 0
C 11110003 1
C 11110004 1
A
E 11110001 0
E 11110002 0
E 11110003 1
E 11110004 1
B a0a0a000 a0a0a001 a0a0a002 a0a0a003 0
B b0b0b000 b0b0b001 b0b0b002 b0b0b003 1
P 5 12
R 2
S
E a0a0a000 0
E a0a0a001 0
E a0a0a002 0
E a0a0a003 0
E b0b0b000 0
E b0b0b001 0
E b0b0b002 0
E b0b0b003 1
C 22220001 0
A
R 1
C 22220002 0
C 22220003 1
B c0c0c000 c0c0c001 c0c0c002 c0c0c003 0
S
E 22220001 0
E 22220002 0
E 22220003 1
E c0c0c000 0
E c0c0c001 0
E c0c0c002 0
E c0c0c003 0
R 0
D 4
B e0e0e000 e0e0e001 e0e0e002 e0e0e003 1
R 1
R 3
S
E e0e0e000 0
E e0e0e001 0
E e0e0e002 0
E e0e0e003 1
C 33330001 0
C 33330002 1
A
E 33330001 0
E 33330002 1
